// ==== logic/glb_defines.svh ====
/*
 * global buffer sizing
 * tile count, address split, word width and bank read latency
 */

`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

// tiles in the chain
`define GLB_NUM_TILES 4

// tile select sits in the top address bits
`define GLB_TILE_SEL_WIDTH 2

// word address inside one bank
`define GLB_BANK_ADDR_WIDTH 6

// full processor word address
`define GLB_ADDR_WIDTH (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH)

// data word
`define GLB_DATA_WIDTH 32

// bank read pipeline stages
`define GLB_RD_LATENCY 2

`endif

// ==== logic/glb_pkg.sv ====
/*
 * global buffer types
 * chain packet structs and bank controller states
 */

`default_nettype none

`include "glb_defines.svh"

package glb_pkg;

    // write request, valid for one cycle when wr_en is set
    typedef struct packed {
        logic                       wr_en;
        logic [`GLB_ADDR_WIDTH-1:0] wr_addr;
        logic [`GLB_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // read request
    typedef struct packed {
        logic                       rd_en;
        logic [`GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // read response back toward the processor
    typedef struct packed {
        logic [`GLB_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;
    } rdrs_packet_t;

    // one word moving along the chain
    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

    // bank controller FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        WAIT    = 2'd1,
        RESPOND = 2'd2
    } bank_state_t;

endpackage

`default_nettype wire

// ==== logic/glb_proc_router.sv ====
/*
 * processor packet router for one tile
 * registers both chain directions, filters this tile's requests
 * and inserts the local read response
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_proc_router #(
    parameter int TILE_ID = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_pkg::packet_t      packet_w2e_in,
    input  glb_pkg::packet_t      packet_e2w_in,
    output glb_pkg::packet_t      packet_w2e_out,
    output glb_pkg::packet_t      packet_e2w_out,
    output glb_pkg::wr_packet_t   wr_packet,
    output glb_pkg::rdrq_packet_t rdrq_packet,
    input  glb_pkg::rdrs_packet_t rdrs_packet
);

    // even tiles listen eastbound, odd tiles westbound
    localparam bit IS_EVEN = (TILE_ID % 2) == 0;
    localparam logic [`GLB_TILE_SEL_WIDTH-1:0] TILE_SEL = TILE_ID[`GLB_TILE_SEL_WIDTH-1:0];

    glb_pkg::packet_t      w2e_q;
    glb_pkg::packet_t      e2w_q;
    glb_pkg::rdrs_packet_t rdrs_q;
    glb_pkg::wr_packet_t   wr_sel;
    glb_pkg::rdrq_packet_t rdrq_sel;
    glb_pkg::rdrs_packet_t w2e_rdrs;
    glb_pkg::rdrs_packet_t e2w_rdrs;

    // one hop per cycle in each direction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w2e_q <= '0;
            e2w_q <= '0;
        end else begin
            w2e_q <= packet_w2e_in;
            e2w_q <= packet_e2w_in;
        end
    end

    // local response lines up with the passing stream one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_q <= '0;
        end else begin
            rdrs_q <= rdrs_packet;
        end
    end

    // requests pass on unchanged
    assign packet_w2e_out.wr   = w2e_q.wr;
    assign packet_w2e_out.rdrq = w2e_q.rdrq;
    assign packet_e2w_out.wr   = e2w_q.wr;
    assign packet_e2w_out.rdrq = e2w_q.rdrq;

    // pick the stream for this tile parity
    assign wr_sel   = IS_EVEN ? w2e_q.wr : e2w_q.wr;
    assign rdrq_sel = IS_EVEN ? w2e_q.rdrq : e2w_q.rdrq;

    // only requests addressed to this tile reach the controller
    assign wr_packet = (wr_sel.wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == TILE_SEL)
                     ? wr_sel : '0;
    assign rdrq_packet = (rdrq_sel.rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH] == TILE_SEL)
                       ? rdrq_sel : '0;

    // response goes out on the same stream the request came from
    assign w2e_rdrs = (IS_EVEN && rdrs_q.rd_data_valid) ? rdrs_q : w2e_q.rdrs;
    assign e2w_rdrs = (!IS_EVEN && rdrs_q.rd_data_valid) ? rdrs_q : e2w_q.rdrs;

    assign packet_w2e_out.rdrs = w2e_rdrs;
    assign packet_e2w_out.rdrs = e2w_rdrs;

endmodule

`default_nettype wire

// ==== logic/glb_bank_ctrl.sv ====
/*
 * bank controller
 * writes go straight to the bank, one read at a time is
 * sequenced through request, wait and response
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_bank_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  glb_pkg::wr_packet_t             wr_packet,
    input  glb_pkg::rdrq_packet_t           rdrq_packet,
    output glb_pkg::rdrs_packet_t           rdrs_packet,
    output logic                            mem_wr_en,
    output logic [`GLB_BANK_ADDR_WIDTH-1:0] mem_wr_addr,
    output logic [`GLB_DATA_WIDTH-1:0]      mem_wr_data,
    output logic                            mem_rd_en,
    output logic [`GLB_BANK_ADDR_WIDTH-1:0] mem_rd_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      mem_rd_data,
    output logic                            timer_start,
    input  logic                            timer_done,
    output glb_pkg::bank_state_t            state
);

    glb_pkg::bank_state_t       state_q;
    glb_pkg::bank_state_t       state_d;
    logic [`GLB_DATA_WIDTH-1:0] rd_data_q;
    logic                       rd_start;

    // write port, taken in any state
    assign mem_wr_en   = wr_packet.wr_en;
    assign mem_wr_addr = wr_packet.wr_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign mem_wr_data = wr_packet.wr_data;

    // a read is only started from IDLE
    assign rd_start = (state_q == glb_pkg::IDLE) && rdrq_packet.rd_en;

    assign mem_rd_en   = rd_start;
    assign mem_rd_addr = rdrq_packet.rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign timer_start = rd_start;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            glb_pkg::IDLE: begin
                if (rd_start) begin
                    state_d = glb_pkg::WAIT;
                end
            end
            glb_pkg::WAIT: begin
                // bank output is ready when the timer fires
                if (timer_done) begin
                    state_d = glb_pkg::RESPOND;
                end
            end
            glb_pkg::RESPOND: begin
                state_d = glb_pkg::IDLE;
            end
            default: begin
                state_d = glb_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= glb_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture read data on the way into RESPOND
    always_ff @(posedge clk) begin
        if (state_q == glb_pkg::WAIT && timer_done) begin
            rd_data_q <= mem_rd_data;
        end
    end

    // response is valid only for the single RESPOND cycle
    assign rdrs_packet.rd_data       = rd_data_q;
    assign rdrs_packet.rd_data_valid = (state_q == glb_pkg::RESPOND);

    assign state = state_q;

endmodule

`default_nettype wire

// ==== logic/glb_rd_wait_timer.sv ====
/*
 * read wait timer
 * counts down the bank read latency and flags when data is ready
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_rd_wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    localparam int CNT_WIDTH = $clog2(`GLB_RD_LATENCY + 1);

    logic [CNT_WIDTH-1:0] count;

    // load on start, otherwise run down to zero and stay there
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_WIDTH'(`GLB_RD_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high in the cycle the last pipeline stage holds the data
    assign done = (count == CNT_WIDTH'(1));

endmodule

`default_nettype wire

// ==== logic/glb_bank_mem.sv ====
/*
 * bank memory
 * one write and one read port, read data goes through
 * a pipeline of GLB_RD_LATENCY stages
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_bank_mem (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      wr_data,
    input  logic                            rd_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0] rd_addr,
    output logic [`GLB_DATA_WIDTH-1:0]      rd_data
);

    localparam int DEPTH = 1 << `GLB_BANK_ADDR_WIDTH;

    logic [`GLB_DATA_WIDTH-1:0] mem [DEPTH];
    logic [`GLB_DATA_WIDTH-1:0] rd_pipe [`GLB_RD_LATENCY];

    // storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // first stage holds the array output, later stages just shift
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_RD_LATENCY; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            if (rd_en) begin
                rd_pipe[0] <= mem[rd_addr];
            end
            for (int i = 1; i < `GLB_RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    assign rd_data = rd_pipe[`GLB_RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== logic/glb_tile.sv ====
/*
 * global buffer tile
 * router, bank controller, read timer and one memory bank
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic             clk,
    input  logic             reset,
    input  glb_pkg::packet_t packet_w2e_in,
    input  glb_pkg::packet_t packet_e2w_in,
    output glb_pkg::packet_t packet_w2e_out,
    output glb_pkg::packet_t packet_e2w_out
);

    glb_pkg::wr_packet_t             wr_packet;
    glb_pkg::rdrq_packet_t           rdrq_packet;
    glb_pkg::rdrs_packet_t           rdrs_packet;
    logic                            mem_wr_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] mem_wr_addr;
    logic [`GLB_DATA_WIDTH-1:0]      mem_wr_data;
    logic                            mem_rd_en;
    logic [`GLB_BANK_ADDR_WIDTH-1:0] mem_rd_addr;
    logic [`GLB_DATA_WIDTH-1:0]      mem_rd_data;
    logic                            timer_start;
    logic                            timer_done;

    // chain side
    glb_proc_router #(
        .TILE_ID(TILE_ID)
    ) i_router (
        .clk           (clk),
        .reset         (reset),
        .packet_w2e_in (packet_w2e_in),
        .packet_e2w_in (packet_e2w_in),
        .packet_w2e_out(packet_w2e_out),
        .packet_e2w_out(packet_e2w_out),
        .wr_packet     (wr_packet),
        .rdrq_packet   (rdrq_packet),
        .rdrs_packet   (rdrs_packet)
    );

    // state output only watched by the bound checks
    glb_bank_ctrl i_bank_ctrl (
        .clk        (clk),
        .reset      (reset),
        .wr_packet  (wr_packet),
        .rdrq_packet(rdrq_packet),
        .rdrs_packet(rdrs_packet),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .mem_rd_en  (mem_rd_en),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_data(mem_rd_data),
        .timer_start(timer_start),
        .timer_done (timer_done),
        .state      ()
    );

    glb_rd_wait_timer i_rd_wait_timer (
        .clk  (clk),
        .reset(reset),
        .start(timer_start),
        .done (timer_done)
    );

    glb_bank_mem i_bank_mem (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (mem_wr_en),
        .wr_addr(mem_wr_addr),
        .wr_data(mem_wr_data),
        .rd_en  (mem_rd_en),
        .rd_addr(mem_rd_addr),
        .rd_data(mem_rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/glb_top.sv ====
/*
 * global buffer top
 * chain of tiles with the processor port at the west end
 * and the eastbound stream looped back west at the east end
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       proc_wr_en,
    input  logic [`GLB_ADDR_WIDTH-1:0] proc_wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                       proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0] proc_rd_addr,
    output logic [`GLB_DATA_WIDTH-1:0] proc_rd_data,
    output logic                       proc_rd_data_valid
);

    // index k is the west side of tile k, index N the east end
    glb_pkg::packet_t w2e [`GLB_NUM_TILES+1];
    glb_pkg::packet_t e2w [`GLB_NUM_TILES+1];

    // processor request enters eastbound with no response
    assign w2e[0].wr.wr_en       = proc_wr_en;
    assign w2e[0].wr.wr_addr     = proc_wr_addr;
    assign w2e[0].wr.wr_data     = proc_wr_data;
    assign w2e[0].rdrq.rd_en     = proc_rd_en;
    assign w2e[0].rdrq.rd_addr   = proc_rd_addr;
    assign w2e[0].rdrs           = '0;

    // turn around at the east end
    assign e2w[`GLB_NUM_TILES] = w2e[`GLB_NUM_TILES];

    for (genvar k = 0; k < `GLB_NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID(k)
        ) i_tile (
            .clk           (clk),
            .reset         (reset),
            .packet_w2e_in (w2e[k]),
            .packet_e2w_in (e2w[k+1]),
            .packet_w2e_out(w2e[k+1]),
            .packet_e2w_out(e2w[k])
        );
    end

    // all responses come home on the westbound stream
    assign proc_rd_data       = e2w[0].rdrs.rd_data;
    assign proc_rd_data_valid = e2w[0].rdrs.rd_data_valid;

endmodule

`default_nettype wire

// ==== sim/glb_asserts.sv ====
/*
 * bank controller checks
 * bound into the controller of every tile
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_asserts (
    input logic                  clk,
    input logic                  reset,
    input glb_pkg::bank_state_t  state,
    input glb_pkg::rdrq_packet_t rdrq_packet,
    input glb_pkg::rdrs_packet_t rdrs_packet,
    input logic                  timer_done
);

    // only one read in flight per bank
    no_read_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        (state != glb_pkg::IDLE) |-> !rdrq_packet.rd_en
    ) else $error("read request reached a busy bank controller");

    // accepted read answers after the bank latency, strobe drops next cycle
    one_response_per_read: assert property (
        @(posedge clk) disable iff (reset)
        (state == glb_pkg::IDLE && rdrq_packet.rd_en)
            |-> ##(`GLB_RD_LATENCY + 1) rdrs_packet.rd_data_valid
                ##1 !rdrs_packet.rd_data_valid
    ) else $error("read response missing, late or longer than one cycle");

    // timer fires only while a read is pending
    done_only_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        timer_done |-> (state == glb_pkg::WAIT)
    ) else $error("read timer done outside of WAIT");

endmodule

bind glb_bank_ctrl glb_asserts i_asserts (
    .clk        (clk),
    .reset      (reset),
    .state      (state),
    .rdrq_packet(rdrq_packet),
    .rdrs_packet(rdrs_packet),
    .timer_done (timer_done)
);

`default_nettype wire

// ==== sim/glb_tb.sv ====
/*
 * global buffer testbench
 * table of writes and reads checked against a reference copy of the banks
 */

`timescale 1ns/1ns
`default_nettype none

`include "glb_defines.svh"

module glb_tb;

    localparam int CLK_HALF  = 50;
    localparam int DRIVE_DLY = 5;
    localparam int NUM_OPS   = 51;
    // worst case cycles for one table row
    localparam int OP_CYCLES = 2 * `GLB_NUM_TILES + `GLB_RD_LATENCY + 10;

    logic                       clk;
    logic                       reset;
    logic                       proc_wr_en;
    logic [`GLB_ADDR_WIDTH-1:0] proc_wr_addr;
    logic [`GLB_DATA_WIDTH-1:0] proc_wr_data;
    logic                       proc_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0] proc_rd_addr;
    logic [`GLB_DATA_WIDTH-1:0] proc_rd_data;
    logic                       proc_rd_data_valid;

    // operation table, one row per request
    logic                       op_is_wr [NUM_OPS];
    logic [`GLB_ADDR_WIDTH-1:0] op_addr  [NUM_OPS];
    logic [`GLB_DATA_WIDTH-1:0] op_data  [NUM_OPS];
    int                         op_count;

    // reference copy of all banks, indexed by full address
    logic [`GLB_DATA_WIDTH-1:0] ref_mem [1 << `GLB_ADDR_WIDTH];

    int          data_errors;
    int          other_errors;
    logic [31:0] seed_ret;

    glb_top i_glb_top (
        .clk               (clk),
        .reset             (reset),
        .proc_wr_en        (proc_wr_en),
        .proc_wr_addr      (proc_wr_addr),
        .proc_wr_data      (proc_wr_data),
        .proc_rd_en        (proc_rd_en),
        .proc_rd_addr      (proc_rd_addr),
        .proc_rd_data      (proc_rd_data),
        .proc_rd_data_valid(proc_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // append one row, write data comes from the seeded generator
    task automatic add_op(input logic is_wr, input int tile, input int bank_addr);
        op_is_wr[op_count] = is_wr;
        op_addr[op_count]  = {tile[`GLB_TILE_SEL_WIDTH-1:0],
                              bank_addr[`GLB_BANK_ADDR_WIDTH-1:0]};
        op_data[op_count]  = is_wr ? $urandom : '0;
        op_count++;
    endtask

    task automatic build_table;
        op_count = 0;
        // write then read on every tile, both parities
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            add_op(1'b1, t, 5);
            add_op(1'b0, t, 5);
        end
        // burst, one write per cycle across all tiles
        for (int b = 10; b < 14; b++) begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                add_op(1'b1, t, b);
            end
        end
        for (int b = 10; b < 14; b++) begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                add_op(1'b0, t, b);
            end
        end
        // later write to the same word wins
        add_op(1'b1, 2, 20);
        add_op(1'b1, 2, 20);
        add_op(1'b0, 2, 20);
        // same bank word in each tile, read back in reverse tile order
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            add_op(1'b1, t, 33);
        end
        for (int t = `GLB_NUM_TILES - 1; t >= 0; t--) begin
            add_op(1'b0, t, 33);
        end
    endtask

    // one cycle write, starts and ends just after a rising edge
    task automatic do_write(input logic [`GLB_ADDR_WIDTH-1:0] addr,
                            input logic [`GLB_DATA_WIDTH-1:0] data);
        proc_wr_en    = 1'b1;
        proc_wr_addr  = addr;
        proc_wr_data  = data;
        ref_mem[addr] = data;
        @(negedge clk);
        if (proc_rd_data_valid) begin
            $display("t=%0t read response seen with no read outstanding", $time);
            other_errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        proc_wr_en = 1'b0;
    endtask

    // read, wait for the single response pulse and compare
    task automatic do_read(input logic [`GLB_ADDR_WIDTH-1:0] addr);
        logic [`GLB_DATA_WIDTH-1:0] expected;
        int                         waited;
        expected     = ref_mem[addr];
        waited       = 0;
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        @(posedge clk);
        #DRIVE_DLY;
        proc_rd_en = 1'b0;
        @(negedge clk);
        while (!proc_rd_data_valid && waited < OP_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!proc_rd_data_valid) begin
            $display("t=%0t no read response for address %h", $time, addr);
            other_errors++;
        end else begin
            if (proc_rd_data !== expected) begin
                $display("ERR t=%0t proc_rd_data expected %h got %h",
                         $time, expected, proc_rd_data);
                data_errors++;
            end
            // pulse must drop after one cycle
            @(negedge clk);
            if (proc_rd_data_valid) begin
                $display("ERR t=%0t proc_rd_data_valid expected 0 got 1", $time);
                data_errors++;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    initial begin
        seed_ret     = $urandom(32'h6d446b42);
        data_errors  = 0;
        other_errors = 0;
        reset        = 1'b1;
        proc_wr_en   = 1'b0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        build_table();
        if (op_count != NUM_OPS) begin
            $display("operation table holds %0d rows instead of %0d", op_count, NUM_OPS);
            other_errors++;
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        // idle chain gives no responses
        repeat (5) begin
            @(negedge clk);
            if (proc_rd_data_valid) begin
                $display("ERR t=%0t proc_rd_data_valid expected 0 got 1", $time);
                data_errors++;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (op_is_wr[i]) begin
                do_write(op_addr[i], op_data[i]);
            end else begin
                do_read(op_addr[i]);
            end
        end
        $display("summary: %0d operations, %0d value errors, %0d other errors",
                 NUM_OPS, data_errors, other_errors);
        if (data_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_OPS * OP_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", NUM_OPS * OP_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/glb_pkg.sv
logic/glb_proc_router.sv
logic/glb_bank_ctrl.sv
logic/glb_rd_wait_timer.sv
logic/glb_bank_mem.sv
logic/glb_tile.sv
logic/glb_top.sv
sim/glb_asserts.sv
sim/glb_tb.sv

// ==== Makefile ====
# Verilator flow for the global buffer testbench

TOOL       = verilator
FILELIST   = verilog.f
TOP        = glb_tb
RTL_TOP    = glb_top
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
